//--- bench/alu_patterns.mem
// en op sat ci x y result flags compd, all hex
// flags bits 4..0 are az an ac av as
1 0 0 0 0003 0004 0007 00 0
1 0 0 0 8000 8000 0000 16 0
1 0 0 0 7FFF 0001 8000 0A 0
1 0 1 0 7FFF 0001 7FFF 02 0
1 1 0 0 8000 0001 7FFF 06 0
1 1 1 0 8000 0001 8000 0E 0
1 1 0 0 0005 0005 0000 14 0
1 2 0 1 0010 0020 0031 00 0
1 3 0 0 0010 0020 FFEF 08 0
1 5 0 0 0005 0000 FFFB 08 0
1 5 0 0 0000 1234 0000 14 0
1 4 0 0 7FFF 7FFF 7FFF 00 0
1 4 0 0 FFFC 0002 FFFF 08 0
1 6 0 0 0005 0005 0000 10 1
1 6 0 0 FFFF 0001 FFFF 08 1
1 6 0 0 0002 FFFE 0001 00 1
0 D 1 1 AAAA 5555 0001 00 0
1 7 0 0 FFF0 0010 FFF0 08 0
1 8 0 0 FFF0 0010 0010 00 0
1 6 0 0 0001 0002 FFFF 08 1
1 9 0 0 FFF0 0020 FFF0 08 0
1 9 0 0 FF00 0010 FFF0 08 0
1 A 0 0 F0F0 0FF0 00F0 00 0
1 A 0 0 0F0F F0F0 0000 10 0
1 B 0 0 8000 0001 8001 08 0
1 C 0 0 FFFF 00FF FF00 08 0
1 D 0 0 0F0F 0000 F0F0 08 0
1 E 0 0 1234 0000 1234 00 0
0 0 1 0 7FFF 7FFF 1234 00 0
1 F 0 0 FFFB 0000 0005 01 0
1 F 0 0 8000 0000 8000 0B 0
1 F 1 0 8000 0000 7FFF 03 0
1 F 0 0 0007 0000 0007 00 0

//--- build.f
+incdir+source
source/alu_ctrl_pkg.sv
source/alu_data_pkg.sv
source/alu_operand_latch.sv
source/alu_adder_unit.sv
source/alu_compare_unit.sv
source/alu_logic_unit.sv
source/alu_result_mux.sv
source/alu_top.sv
bench/alu_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f build.f --top-module alu_tb -Mdir obj_dir -o alu_sim
	./obj_dir/alu_sim 2>&1 | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/alu_tb.sv
//--------------------------------------------------------------------------
// Replays bench/alu_patterns.mem with one operation per line
// NUM_PATTERNS must match the number of lines in the pattern file
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module alu_tb;

    localparam int NUM_PATTERNS   = 33;
    localparam int FIELDS         = 9;    // Words per pattern line
    localparam int TIMEOUT_CYCLES = NUM_PATTERNS * 2 + 20;

    logic                        clk;
    logic                        reset;
    logic                        alu_en;
    alu_ctrl_pkg::alu_ctrl_t     ctrl;
    alu_data_pkg::alu_operands_t operands;
    alu_data_pkg::alu_word_t     result;
    alu_data_pkg::alu_flags_t    flags;
    logic                        compd;

    // One word each for en op sat ci x y result flags compd
    logic [15:0] pattern_mem [0:NUM_PATTERNS*FIELDS-1];
    int          cycle_count = 0;

    alu_top u_dut
    (
        .clk      (clk),
        .reset    (reset),
        .alu_en   (alu_en),
        .ctrl     (ctrl),
        .operands (operands),
        .result   (result),
        .flags    (flags),
        .compd    (compd)
    );

    always #20 clk = ~clk;    // 40 ns period

    //----------------------------------------------------------------------
    // Failure handling and compare tasks
    //----------------------------------------------------------------------
    task automatic abort_run;
        $display("Simulation failed");
        $fatal(1, "Stopping at the first failure");
    endtask

    task automatic check_word(input alu_data_pkg::alu_word_t got,
                              input alu_data_pkg::alu_word_t expected,
                              input string what);
        if (got !== expected)
        begin
            $display("ERR %0t: %s result %h, expected %h", $time, what, got, expected);
            abort_run();
        end
    endtask

    task automatic check_flags(input alu_data_pkg::alu_flags_t got,
                               input alu_data_pkg::alu_flags_t expected,
                               input string what);
        if (got !== expected)
        begin
            $display("ERR %0t: %s flags (az an ac av as) %b, expected %b",
                     $time, what, got, expected);
            abort_run();
        end
    endtask

    task automatic check_compd(input logic got,
                               input logic expected,
                               input string what);
        if (got !== expected)
        begin
            $display("ERR %0t: %s compd %b, expected %b", $time, what, got, expected);
            abort_run();
        end
    endtask

    //----------------------------------------------------------------------
    // Pattern access
    //----------------------------------------------------------------------
    task automatic drive_pattern(input int idx);
        int base;
        base = idx * FIELDS;
        alu_en     <= pattern_mem[base][0];
        ctrl.op    <= alu_ctrl_pkg::alu_op_e'(pattern_mem[base+1][3:0]);
        ctrl.sat   <= pattern_mem[base+2][0];
        ctrl.ci    <= pattern_mem[base+3][0];
        operands.x <= pattern_mem[base+4];
        operands.y <= pattern_mem[base+5];
    endtask

    task automatic check_pattern(input int idx);
        int    base;
        string what;
        base = idx * FIELDS;
        what = $sformatf("pattern %0d", idx);
        check_word(result, pattern_mem[base+6], what);
        check_flags(flags, alu_data_pkg::alu_flags_t'(pattern_mem[base+7][4:0]), what);
        check_compd(compd, pattern_mem[base+8][0], what);
    endtask

    // Hung run guard
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: pattern replay did not finish within %0d cycles",
                     TIMEOUT_CYCLES);
            abort_run();
        end
    end

    //----------------------------------------------------------------------
    // Stimulus
    //----------------------------------------------------------------------
    initial
    begin
        clk      = 1'b0;
        reset    = 1'b0;
        alu_en   = 1'b0;
        ctrl     = '{op: alu_ctrl_pkg::OP_PASS, sat: 1'b0, ci: 1'b0};
        operands = '0;
        $readmemh("bench/alu_patterns.mem", pattern_mem);

        repeat (3) @(posedge clk);
        reset <= 1'b1;

        // Nothing captured yet so PASS of the reset x shows
        @(negedge clk);
        check_word(result, 16'h0001, "reset");
        check_flags(flags, '0, "reset");
        check_compd(compd, 1'b0, "reset");

        @(posedge clk);
        drive_pattern(0);
        for (int i = 0; i < NUM_PATTERNS; i++)
        begin
            @(posedge clk);    // Pattern i captured here
            if (i + 1 < NUM_PATTERNS)
                drive_pattern(i + 1);    // Back to back
            else
                alu_en <= 1'b0;
            @(negedge clk);
            check_pattern(i);
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

//--- source/alu_top.sv
//--------------------------------------------------------------------------
// 16-bit fixed-point ALU, one cycle from enable to result and flags
// No back-pressure; each capture replaces the previous operation
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module alu_top
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        alu_en,
    input  alu_ctrl_pkg::alu_ctrl_t     ctrl,
    input  alu_data_pkg::alu_operands_t operands,
    output alu_data_pkg::alu_word_t     result,
    output alu_data_pkg::alu_flags_t    flags,
    output logic                        compd
);

    alu_ctrl_pkg::alu_ctrl_t        ctrl_q;
    alu_data_pkg::alu_operands_t    operands_q;
    logic                           en_q;
    alu_data_pkg::alu_unit_result_t add_res;
    alu_data_pkg::alu_unit_result_t cmp_res;
    alu_data_pkg::alu_unit_result_t logic_res;

    alu_operand_latch u_latch (.clk(clk), .reset(reset), .alu_en(alu_en),
                               .ctrl_in(ctrl), .operands_in(operands),
                               .ctrl_q(ctrl_q), .operands_q(operands_q), .en_q(en_q));

    alu_adder_unit u_adder (.ctrl(ctrl_q), .operands(operands_q), .add_res(add_res));

    alu_compare_unit u_compare (.op(ctrl_q.op), .operands(operands_q), .cmp_res(cmp_res));

    alu_logic_unit u_logic (.ctrl(ctrl_q), .operands(operands_q), .logic_res(logic_res));

    alu_result_mux u_mux (.ctrl(ctrl_q), .operands(operands_q), .en_q(en_q),
                          .add_res(add_res), .cmp_res(cmp_res), .logic_res(logic_res),
                          .result(result), .flags(flags), .compd(compd));

endmodule

//--- source/alu_result_mux.sv
//--------------------------------------------------------------------------
// Result select by opcode group, flag generation and compare-done strobe
// Purely combinational, outputs follow the latched operation
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module alu_result_mux
(
    input  alu_ctrl_pkg::alu_ctrl_t        ctrl,
    input  alu_data_pkg::alu_operands_t    operands,
    input  logic                           en_q,
    input  alu_data_pkg::alu_unit_result_t add_res,
    input  alu_data_pkg::alu_unit_result_t cmp_res,
    input  alu_data_pkg::alu_unit_result_t logic_res,
    output alu_data_pkg::alu_word_t        result,
    output alu_data_pkg::alu_flags_t       flags,
    output logic                           compd
);

    alu_ctrl_pkg::alu_group_e       grp;
    alu_data_pkg::alu_unit_result_t sel;

    //----------------------------------------------------------------------
    // Opcode to group
    //----------------------------------------------------------------------
    always_comb
    begin
        case (ctrl.op)
            alu_ctrl_pkg::OP_ADD, alu_ctrl_pkg::OP_SUB,
            alu_ctrl_pkg::OP_ADD_CI, alu_ctrl_pkg::OP_SUB_CI,
            alu_ctrl_pkg::OP_AVG, alu_ctrl_pkg::OP_NEG:
                grp = alu_ctrl_pkg::GRP_ADDER;
            alu_ctrl_pkg::OP_COMP, alu_ctrl_pkg::OP_MIN,
            alu_ctrl_pkg::OP_MAX, alu_ctrl_pkg::OP_CLIP:
                grp = alu_ctrl_pkg::GRP_COMPARE;
            default:
                grp = alu_ctrl_pkg::GRP_LOGIC;    // Logic ops and ABS
        endcase
    end

    always_comb
    begin
        case (grp)
            alu_ctrl_pkg::GRP_ADDER:   sel = add_res;
            alu_ctrl_pkg::GRP_COMPARE: sel = cmp_res;
            default:                   sel = logic_res;
        endcase
    end

    assign result   = sel.data;
    assign flags.az = (sel.data == 16'h0000);
    assign flags.an = sel.data[15];
    assign flags.ac = sel.ac;
    assign flags.av = sel.av;
    assign flags.as = (ctrl.op == alu_ctrl_pkg::OP_ABS) && operands.x[15];

    // One cycle per capture of a COMP
    assign compd = en_q && (ctrl.op == alu_ctrl_pkg::OP_COMP);

    always_comb
    begin
        a_carry_adder_only : assert final (grp == alu_ctrl_pkg::GRP_ADDER || !flags.ac)
            else $error("Carry flag set outside the adder group");
    end

endmodule

//--- source/alu_logic_unit.sv
//--------------------------------------------------------------------------
// Bitwise operations, PASS and ABS; only ABS of 8000 sets overflow
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "alu_params.svh"

module alu_logic_unit
(
    input  alu_ctrl_pkg::alu_ctrl_t        ctrl,
    input  alu_data_pkg::alu_operands_t    operands,
    output alu_data_pkg::alu_unit_result_t logic_res
);

    logic                    x_min_neg;    // x is 8000
    alu_data_pkg::alu_word_t abs_x;

    assign x_min_neg = (operands.x == `ALU_SAT_NEG);
    assign abs_x     = operands.x[15] ? (~operands.x + 16'd1) : operands.x;

    always_comb
    begin
        logic_res.ac = 1'b0;
        logic_res.av = 1'b0;
        case (ctrl.op)
            alu_ctrl_pkg::OP_AND:
                logic_res.data = operands.x & operands.y;
            alu_ctrl_pkg::OP_OR:
                logic_res.data = operands.x | operands.y;
            alu_ctrl_pkg::OP_XOR:
                logic_res.data = operands.x ^ operands.y;
            alu_ctrl_pkg::OP_NOT:
                logic_res.data = ~operands.x;
            alu_ctrl_pkg::OP_ABS:
            begin
                logic_res.av = x_min_neg;
                // |8000| does not fit, wraps back to 8000 unless saturating
                if (x_min_neg && ctrl.sat)
                    logic_res.data = `ALU_SAT_POS;
                else
                    logic_res.data = abs_x;
            end
            default:
                logic_res.data = operands.x;    // PASS
        endcase
    end

endmodule

//--- source/alu_compare_unit.sv
//--------------------------------------------------------------------------
// Signed compare, MIN, MAX and CLIP; never sets overflow or carry
// CLIP magnitudes are unsigned, so |8000| counts as 8000
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module alu_compare_unit
(
    input  alu_ctrl_pkg::alu_op_e          op,
    input  alu_data_pkg::alu_operands_t    operands,
    output alu_data_pkg::alu_unit_result_t cmp_res
);

    logic                    x_eq;
    logic                    x_gt;    // Signed x > y
    alu_data_pkg::alu_word_t mag_x;
    alu_data_pkg::alu_word_t mag_y;
    alu_data_pkg::alu_word_t clip_val;

    assign x_eq = (operands.x == operands.y);
    assign x_gt = ($signed(operands.x) > $signed(operands.y));

    // Two's-complement magnitudes
    assign mag_x = operands.x[15] ? (~operands.x + 16'd1) : operands.x;
    assign mag_y = operands.y[15] ? (~operands.y + 16'd1) : operands.y;

    // |y| carrying the sign of x
    assign clip_val = operands.x[15] ? (~mag_y + 16'd1) : mag_y;

    always_comb
    begin
        cmp_res.av = 1'b0;
        cmp_res.ac = 1'b0;
        case (op)
            alu_ctrl_pkg::OP_COMP:
            begin
                if (x_eq)
                    cmp_res.data = 16'h0000;
                else
                    cmp_res.data = x_gt ? 16'h0001 : 16'hFFFF;
            end
            alu_ctrl_pkg::OP_MIN:
                cmp_res.data = x_gt ? operands.y : operands.x;
            alu_ctrl_pkg::OP_MAX:
                cmp_res.data = x_gt ? operands.x : operands.y;
            alu_ctrl_pkg::OP_CLIP:
            begin
                if (mag_x <= mag_y)
                    cmp_res.data = operands.x;    // Already in range
                else
                    cmp_res.data = clip_val;
            end
            default:
                cmp_res.data = operands.x;
        endcase
    end

endmodule

//--- source/alu_adder_unit.sv
//--------------------------------------------------------------------------
// Shared adder for ADD, SUB, ADD_CI, SUB_CI, AVG and NEG
// AVG never overflows; carry out is bit 16 of the unsigned sum
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "alu_params.svh"

module alu_adder_unit
(
    input  alu_ctrl_pkg::alu_ctrl_t            ctrl,
    input  alu_data_pkg::alu_operands_t        operands,
    output alu_data_pkg::alu_unit_result_t     add_res
);

    logic [`ALU_DATA_WIDTH-1:0] a_term;
    logic [`ALU_DATA_WIDTH-1:0] b_term;
    logic                       cin;
    logic [`ALU_DATA_WIDTH:0]   sum_u;    // Unsigned sum with carry
    logic [`ALU_DATA_WIDTH:0]   sum_s;    // Sign-extended sum for AVG
    logic                       ovf;

    // Operand steering
    always_comb
    begin
        a_term = operands.x;
        b_term = operands.y;
        cin    = 1'b0;
        case (ctrl.op)
            alu_ctrl_pkg::OP_SUB:
            begin
                b_term = ~operands.y;
                cin    = 1'b1;
            end
            alu_ctrl_pkg::OP_ADD_CI:
                cin = ctrl.ci;
            alu_ctrl_pkg::OP_SUB_CI:
            begin
                b_term = ~operands.y;
                cin    = ctrl.ci;
            end
            alu_ctrl_pkg::OP_NEG:
            begin
                a_term = '0;
                b_term = ~operands.x;
                cin    = 1'b1;
            end
            default:
                cin = 1'b0;    // ADD, AVG
        endcase
    end

    assign sum_u = {1'b0, a_term} + {1'b0, b_term} + {{`ALU_DATA_WIDTH{1'b0}}, cin};
    assign sum_s = {a_term[15], a_term} + {b_term[15], b_term};

    // Same input signs, different result sign
    assign ovf = (a_term[15] == b_term[15]) && (sum_u[15] != a_term[15]);

    always_comb
    begin
        add_res.ac = sum_u[16];
        if (ctrl.op == alu_ctrl_pkg::OP_AVG)
        begin
            add_res.data = sum_s[16:1];    // Arithmetic halve
            add_res.av   = 1'b0;
        end
        else
        begin
            add_res.av = ovf;
            if (ovf && ctrl.sat)
                add_res.data = a_term[15] ? `ALU_SAT_NEG : `ALU_SAT_POS;
            else
                add_res.data = sum_u[15:0];
        end
    end

    // The halved sum always lies between the two operands
    always_comb
    begin
        a_avg_in_range : assert final (ctrl.op != alu_ctrl_pkg::OP_AVG
            || (($signed(add_res.data) >= $signed(operands.x)
                 || $signed(add_res.data) >= $signed(operands.y))
                && ($signed(add_res.data) <= $signed(operands.x)
                 || $signed(add_res.data) <= $signed(operands.y))))
            else $error("AVG result outside the operand range");
    end

endmodule

//--- source/alu_operand_latch.sv
//--------------------------------------------------------------------------
// Execute-stage registers, loaded on alu_en and held otherwise
// Reset leaves PASS of x selected so the result reads 0001
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`include "alu_params.svh"

module alu_operand_latch
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        alu_en,
    input  alu_ctrl_pkg::alu_ctrl_t     ctrl_in,
    input  alu_data_pkg::alu_operands_t operands_in,
    output alu_ctrl_pkg::alu_ctrl_t     ctrl_q,
    output alu_data_pkg::alu_operands_t operands_q,
    output logic                        en_q
);

    always_ff @(posedge clk or negedge reset)
    begin
        if (!reset)
        begin
            ctrl_q     <= '{op: alu_ctrl_pkg::OP_PASS, sat: 1'b0, ci: 1'b0};
            operands_q <= '{x: `ALU_RESET_X, y: `ALU_RESET_Y};
            en_q       <= 1'b0;
        end
        else
        begin
            en_q <= alu_en;    // Drives compd in the result cycle
            if (alu_en)
            begin
                ctrl_q     <= ctrl_in;
                operands_q <= operands_in;
            end
        end
    end

    //----------------------------------------------------------------------
    // Checks
    //----------------------------------------------------------------------
    // An X opcode would leave the result group undefined for a whole cycle
    property p_op_known;
        @(posedge clk) disable iff (!reset)
            alu_en |-> !$isunknown(ctrl_in.op);
    endproperty

    a_op_known : assert property (p_op_known)
        else $error("Opcode has unknown bits at capture");

endmodule

//--- source/alu_data_pkg.sv
//--------------------------------------------------------------------------
// Data types: word, operand pair, unit result and status flags
//--------------------------------------------------------------------------
`include "alu_params.svh"

package alu_data_pkg;

    typedef logic [`ALU_DATA_WIDTH-1:0] alu_word_t;

    typedef struct packed {
        alu_word_t x;
        alu_word_t y;
    } alu_operands_t;

    // What each unit hands to the result mux
    typedef struct packed {
        alu_word_t data;
        logic      av;    // Overflow
        logic      ac;    // Carry out
    } alu_unit_result_t;

    typedef struct packed {
        logic az;    // Zero
        logic an;    // Negative
        logic ac;    // Carry
        logic av;    // Overflow
        logic as;    // Sign of x for ABS
    } alu_flags_t;

endpackage

//--- source/alu_ctrl_pkg.sv
//--------------------------------------------------------------------------
// Control types: opcode, result group and latched control word
//--------------------------------------------------------------------------
package alu_ctrl_pkg;

    // Opcode, encoded 0 to 15 in this order
    typedef enum logic [3:0] {
        OP_ADD    = 4'd0,
        OP_SUB    = 4'd1,
        OP_ADD_CI = 4'd2,
        OP_SUB_CI = 4'd3,
        OP_AVG    = 4'd4,
        OP_NEG    = 4'd5,
        OP_COMP   = 4'd6,
        OP_MIN    = 4'd7,
        OP_MAX    = 4'd8,
        OP_CLIP   = 4'd9,
        OP_AND    = 4'd10,
        OP_OR     = 4'd11,
        OP_XOR    = 4'd12,
        OP_NOT    = 4'd13,
        OP_PASS   = 4'd14,
        OP_ABS    = 4'd15
    } alu_op_e;

    // Unit that owns the result
    typedef enum logic [1:0] {
        GRP_ADDER   = 2'd0,
        GRP_COMPARE = 2'd1,
        GRP_LOGIC   = 2'd2
    } alu_group_e;

    typedef struct packed {
        alu_op_e op;
        logic    sat;    // Saturate on overflow
        logic    ci;     // Carry in for ADD_CI / SUB_CI
    } alu_ctrl_t;

endpackage

//--- source/alu_params.svh
//--------------------------------------------------------------------------
// Word width and saturation limits of the 16-bit fixed-point ALU
// Flag and saturation logic assume a 16-bit word, so width is not tunable
//--------------------------------------------------------------------------
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

`define ALU_DATA_WIDTH 16

// Saturation limits, two's complement
`define ALU_SAT_POS 16'h7FFF
`define ALU_SAT_NEG 16'h8000

// Operand registers after reset, PASS of x gives 0001
`define ALU_RESET_X 16'h0001
`define ALU_RESET_Y 16'h0000

`endif
